// File: verilog/sms_bus_pkg.sv
`default_nettype none

// Z80 side address map and bus encodings
package sms_bus_pkg;

    // Bus word types
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [4:0]  bank_t;

    ////////////////////////////////////////
    // Memory space
    ////////////////////////////////////////

    // Mapper registers at the top of slot 3
    localparam addr_t ADDR_BANK2   = 16'hFFFF;
    localparam addr_t ADDR_BANK1   = 16'hFFFE;
    localparam addr_t ADDR_BANK0   = 16'hFFFD;
    localparam addr_t ADDR_RAMCTRL = 16'hFFFC;

    // Slot code of the work RAM in a[15:14]
    localparam logic [1:0] SLOT_INTRAM = 2'd3;

    // First 1 KB of slot 0 stays on bank 0
    localparam addr_t BANK0_FIXED_END = 16'h0400;

    // Bank register values after reset
    localparam bank_t BANK0_RESET = 5'd0;
    localparam bank_t BANK1_RESET = 5'd1;
    localparam bank_t BANK2_RESET = 5'd2;

    // 8 KB work RAM, mirrored over the 16 KB slot
    localparam int INTRAM_AW = 13;

    ////////////////////////////////////////
    // I/O space
    ////////////////////////////////////////

    // Port codes built from {a7, a6, a0}
    localparam logic [2:0] IO_REGION  = 3'b001;
    localparam logic [2:0] IO_PORT_DC = 3'b110;
    localparam logic [2:0] IO_PORT_DD = 3'b111;

    // Value seen on reads nobody answers
    localparam data_t IDLE_READ = 8'hFF;

endpackage

`default_nettype wire

// File: verilog/sms_pad_pkg.sv
`default_nettype none

// Hand controller connector layout
package sms_pad_pkg;

    // Raw connector byte, buttons active low
    typedef logic [7:0] pad_t;

    // Bit positions on each connector
    localparam int PAD_DOWN  = 0;
    localparam int PAD_RIGHT = 1;
    localparam int PAD_UP    = 2;
    localparam int PAD_LEFT  = 3;
    localparam int PAD_TR    = 5;
    localparam int PAD_TL    = 6;

    ////////////////////////////////////////
    // Region latch at port $3F
    ////////////////////////////////////////

    // Write data bits that land in the latch
    localparam int REGION_BIT_HI = 7;
    localparam int REGION_BIT_LO = 5;

    // Both bits high out of reset
    localparam logic [1:0] REGION_RESET = 2'b11;

endpackage

`default_nettype wire

// File: verilog/bus_strobe_sync.sv
`default_nettype none
`timescale 1ns/1ps

module bus_strobe_sync (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_n,
    input  logic               wr_n,
    input  sms_bus_pkg::data_t d_in,
    output logic               bus_read,
    output logic               bus_write,
    output sms_bus_pkg::data_t wr_data
);

    logic [2:0] rd_n_sr;
    logic [2:0] wr_n_sr;

    // Strobe history, newest sample in bit 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_n_sr <= 3'b111;
            wr_n_sr <= 3'b111;
        end else begin
            rd_n_sr <= {rd_n_sr[1:0], rd_n};
            wr_n_sr <= {wr_n_sr[1:0], wr_n};
        end
    end

    // Falling edge between the two settled stages
    assign bus_read  = (rd_n_sr[2:1] == 2'b10);
    assign bus_write = (wr_n_sr[2:1] == 2'b10);

    // Track the data bus for as long as the write strobe is low
    always_ff @(posedge clk) begin
        if (!wr_n)
            wr_data <= d_in;
    end

    // The CPU never reads and writes in one bus cycle
    a_no_read_write_overlap: assert property (
        @(posedge clk) disable iff (reset) !(bus_read && bus_write)
    );

endmodule

`default_nettype wire

// File: verilog/memory_map.sv
`default_nettype none
`timescale 1ns/1ps

module memory_map (
    input  logic               clk,
    input  logic               reset,
    input  sms_bus_pkg::addr_t a,
    input  logic               mreq_n,
    input  logic               wr_n,
    input  logic               bus_read,
    input  logic               bus_write,
    input  sms_bus_pkg::data_t wr_data,
    output sms_bus_pkg::bank_t ba,
    output logic               ram_ce_n,
    output logic               ram_we_n,
    output logic               mem_hit,
    output sms_bus_pkg::data_t mem_rddata
);

    logic [1:0]         slot;
    logic               sel_ext;
    logic               reg_write;
    logic               startup_mode;
    sms_bus_pkg::bank_t bank0;
    sms_bus_pkg::bank_t bank1;
    sms_bus_pkg::bank_t bank2;

    sms_bus_pkg::data_t intram [2**sms_bus_pkg::INTRAM_AW];

    assign slot      = a[15:14];
    assign mem_hit   = !mreq_n && (slot == sms_bus_pkg::SLOT_INTRAM);
    assign reg_write = bus_write && !mreq_n;

    ////////////////////////////////////////
    // Slot mapper
    ////////////////////////////////////////

    always_comb begin
        case (slot)
            2'd0:    ba = (a < sms_bus_pkg::BANK0_FIXED_END) ? '0 : bank0;
            2'd1:    ba = bank1;
            2'd2:    ba = bank2;
            default: ba = '0;
        endcase
    end

    // Bank registers and the startup flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank0        <= sms_bus_pkg::BANK0_RESET;
            bank1        <= sms_bus_pkg::BANK1_RESET;
            bank2        <= sms_bus_pkg::BANK2_RESET;
            startup_mode <= 1'b1;
        end else if (reg_write) begin
            if (a == sms_bus_pkg::ADDR_BANK0)
                bank0 <= wr_data[4:0];
            if (a == sms_bus_pkg::ADDR_BANK1)
                bank1 <= wr_data[4:0];
            if (a == sms_bus_pkg::ADDR_BANK2)
                bank2 <= wr_data[4:0];
            // Any write here ends startup for good
            if (a == sms_bus_pkg::ADDR_RAMCTRL)
                startup_mode <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // External 512 KB RAM
    ////////////////////////////////////////

    // Writable only while the startup flag is set
    assign sel_ext  = !mreq_n && (slot != sms_bus_pkg::SLOT_INTRAM)
                      && (wr_n || startup_mode);
    assign ram_ce_n = !sel_ext;
    assign ram_we_n = !(sel_ext && !wr_n && startup_mode);

    ////////////////////////////////////////
    // Internal work RAM
    ////////////////////////////////////////

    // Register writes also land in the RAM underneath
    always_ff @(posedge clk) begin
        if (reg_write && mem_hit)
            intram[a[sms_bus_pkg::INTRAM_AW-1:0]] <= wr_data;
    end

    // Free running read, ready one cycle after the address
    always_ff @(posedge clk) begin
        mem_rddata <= intram[a[sms_bus_pkg::INTRAM_AW-1:0]];
    end

    // Read pulse into work RAM finds the address already settled
    a_read_addr_stable: assert property (
        @(posedge clk) disable iff (reset) (bus_read && mem_hit) |-> $stable(a)
    );

endmodule

`default_nettype wire

// File: verilog/pad_ports.sv
`default_nettype none
`timescale 1ns/1ps

module pad_ports (
    input  logic               clk,
    input  logic               reset,
    input  sms_bus_pkg::addr_t a,
    input  logic               iorq_n,
    input  logic               bus_write,
    input  sms_bus_pkg::data_t wr_data,
    input  sms_pad_pkg::pad_t  hc1,
    input  sms_pad_pkg::pad_t  hc2,
    output logic               io_hit,
    output sms_bus_pkg::data_t io_rddata
);

    logic [2:0]         io_addr;
    logic [1:0]         region;
    sms_pad_pkg::pad_t  hc1_r;
    sms_pad_pkg::pad_t  hc1_rr;
    sms_pad_pkg::pad_t  hc2_r;
    sms_pad_pkg::pad_t  hc2_rr;
    sms_bus_pkg::data_t port_dc;
    sms_bus_pkg::data_t port_dd;

    // Partial decode on a7, a6 and a0 as on the real console
    assign io_addr = {a[7], a[6], a[0]};
    assign io_hit  = !iorq_n;

    ////////////////////////////////////////
    // Connector synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        hc1_r  <= hc1;
        hc1_rr <= hc1_r;
        hc2_r  <= hc2;
        hc2_rr <= hc2_r;
    end

    // Region latch at $3F
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            region <= sms_pad_pkg::REGION_RESET;
        else if (bus_write && io_hit && io_addr == sms_bus_pkg::IO_REGION)
            region <= {wr_data[sms_pad_pkg::REGION_BIT_HI],
                       wr_data[sms_pad_pkg::REGION_BIT_LO]};
    end

    ////////////////////////////////////////
    // Joypad ports
    ////////////////////////////////////////

    // Port DC holds all of pad A and the vertical pair of pad B
    assign port_dc = {hc2_rr[sms_pad_pkg::PAD_DOWN],
                      hc2_rr[sms_pad_pkg::PAD_UP],
                      hc1_rr[sms_pad_pkg::PAD_TR],
                      hc1_rr[sms_pad_pkg::PAD_TL],
                      hc1_rr[sms_pad_pkg::PAD_RIGHT],
                      hc1_rr[sms_pad_pkg::PAD_LEFT],
                      hc1_rr[sms_pad_pkg::PAD_DOWN],
                      hc1_rr[sms_pad_pkg::PAD_UP]};

    // Port DD carries the rest of pad B under the region bits
    assign port_dd = {region,
                      2'b11,
                      hc2_rr[sms_pad_pkg::PAD_TR],
                      hc2_rr[sms_pad_pkg::PAD_TL],
                      hc2_rr[sms_pad_pkg::PAD_RIGHT],
                      hc2_rr[sms_pad_pkg::PAD_LEFT]};

    always_comb begin
        case (io_addr)
            sms_bus_pkg::IO_PORT_DC: io_rddata = port_dc;
            sms_bus_pkg::IO_PORT_DD: io_rddata = port_dd;
            default:                 io_rddata = sms_bus_pkg::IDLE_READ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/bus_readback.sv
`default_nettype none
`timescale 1ns/1ps

module bus_readback (
    input  logic               rd_n,
    input  logic               mem_hit,
    input  logic               io_hit,
    input  sms_bus_pkg::data_t mem_rddata,
    input  sms_bus_pkg::data_t io_rddata,
    output sms_bus_pkg::data_t d_out,
    output logic               d_oe
);

    // Memory side first, then I/O, else the idle pattern
    always_comb begin
        if (mem_hit)
            d_out = mem_rddata;
        else if (io_hit)
            d_out = io_rddata;
        else
            d_out = sms_bus_pkg::IDLE_READ;
    end

    // Drive the bus only for cycles we answer
    assign d_oe = !rd_n && (mem_hit || io_hit);

    // At the end of each read the two sides were not both selected
    a_single_source: assert property (
        @(posedge rd_n) !(mem_hit === 1'b1 && io_hit === 1'b1)
    );

endmodule

`default_nettype wire

// File: verilog/sms_bus_top.sv
`default_nettype none
`timescale 1ns/1ps

module sms_bus_top (
    input  logic               clk,
    input  logic               reset,
    input  sms_bus_pkg::addr_t a,
    input  sms_bus_pkg::data_t d_in,
    output sms_bus_pkg::data_t d_out,
    output logic               d_oe,
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               mreq_n,
    input  logic               iorq_n,
    output sms_bus_pkg::bank_t ba,
    output logic               ram_ce_n,
    output logic               ram_we_n,
    input  sms_pad_pkg::pad_t  hc1,
    input  sms_pad_pkg::pad_t  hc2
);

    logic               bus_read;
    logic               bus_write;
    sms_bus_pkg::data_t wr_data;
    logic               mem_hit;
    sms_bus_pkg::data_t mem_rddata;
    logic               io_hit;
    sms_bus_pkg::data_t io_rddata;

    ////////////////////////////////////////
    // Strobe pulses and write data
    ////////////////////////////////////////

    bus_strobe_sync u_strobe (
        .clk       (clk),
        .reset     (reset),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .d_in      (d_in),
        .bus_read  (bus_read),
        .bus_write (bus_write),
        .wr_data   (wr_data)
    );

    ////////////////////////////////////////
    // Memory and I/O decode
    ////////////////////////////////////////

    memory_map u_mem (
        .clk        (clk),
        .reset      (reset),
        .a          (a),
        .mreq_n     (mreq_n),
        .wr_n       (wr_n),
        .bus_read   (bus_read),
        .bus_write  (bus_write),
        .wr_data    (wr_data),
        .ba         (ba),
        .ram_ce_n   (ram_ce_n),
        .ram_we_n   (ram_we_n),
        .mem_hit    (mem_hit),
        .mem_rddata (mem_rddata)
    );

    pad_ports u_pads (
        .clk       (clk),
        .reset     (reset),
        .a         (a),
        .iorq_n    (iorq_n),
        .bus_write (bus_write),
        .wr_data   (wr_data),
        .hc1       (hc1),
        .hc2       (hc2),
        .io_hit    (io_hit),
        .io_rddata (io_rddata)
    );

    // Data bus return path
    bus_readback u_readback (
        .rd_n       (rd_n),
        .mem_hit    (mem_hit),
        .io_hit     (io_hit),
        .mem_rddata (mem_rddata),
        .io_rddata  (io_rddata),
        .d_out      (d_out),
        .d_oe       (d_oe)
    );

endmodule

`default_nettype wire

// File: verification/tb_sms_model.svh
`ifndef TB_SMS_MODEL_SVH
`define TB_SMS_MODEL_SVH

// Bank number the mapper should put on ba
function automatic logic [4:0] model_ba(input logic [15:0] addr, input logic [4:0] b0,
                                        input logic [4:0] b1, input logic [4:0] b2);
    case (addr[15:14])
        2'd0:    return (addr < 16'h0400) ? 5'd0 : b0;
        2'd1:    return b1;
        2'd2:    return b2;
        default: return 5'd0;
    endcase
endfunction

// External RAM select, never in the work RAM slot
function automatic logic model_ce_n(input logic [15:0] addr, input logic mem,
                                    input logic write, input logic startup);
    return !(mem && addr[15:14] != 2'b11 && (!write || startup));
endfunction

// Write enable only while still in startup
function automatic logic model_we_n(input logic [15:0] addr, input logic mem,
                                    input logic write, input logic startup);
    return !(mem && addr[15:14] != 2'b11 && write && startup);
endfunction

// I/O read value from {a7, a6, a0}
function automatic logic [7:0] model_port(input logic [15:0] addr, input logic [7:0] p1,
                                          input logic [7:0] p2, input logic [1:0] reg_bits);
    case ({addr[7], addr[6], addr[0]})
        3'b110:  return {p2[0], p2[2], p1[5], p1[6], p1[1], p1[3], p1[0], p1[2]};
        3'b111:  return {reg_bits, 2'b11, p2[5], p2[6], p2[1], p2[3]};
        default: return 8'hFF;
    endcase
endfunction

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

`endif

// File: verification/tb_sms_bus.sv
`default_nettype none
`timescale 1ns/1ps

module tb_sms_bus;

    `include "tb_sms_model.svh"

    // Tests take about 1000 cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int HOLD_CYCLES    = 5;

    logic               clk;
    logic               reset;
    sms_bus_pkg::addr_t a;
    sms_bus_pkg::data_t d_in;
    sms_bus_pkg::data_t d_out;
    logic               d_oe;
    logic               rd_n;
    logic               wr_n;
    logic               mreq_n;
    logic               iorq_n;
    sms_bus_pkg::bank_t ba;
    logic               ram_ce_n;
    logic               ram_we_n;
    sms_pad_pkg::pad_t  hc1;
    sms_pad_pkg::pad_t  hc2;

    // Model state
    logic [4:0]  bank0;
    logic [4:0]  bank1;
    logic [4:0]  bank2;
    logic        startup;
    logic [1:0]  region;
    logic [7:0]  ram_model [8192];
    logic [15:0] written [$];
    logic [31:0] rng;

    // Expected outputs at the next rising edge
    logic        checking;
    logic        data_check;
    logic [4:0]  exp_ba;
    logic        exp_ce_n;
    logic        exp_we_n;
    logic        exp_oe;
    logic [7:0]  exp_d;

    int errors;
    int checks;
    int cycle_count;

    sms_bus_top sms_bus_top_i (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (checking) begin
            checks = checks + 4;
            if (ba !== exp_ba) begin
                errors = errors + 1;
                $display("mismatch ba: got %h expected %h at a=%h", ba, exp_ba, a);
            end
            if (ram_ce_n !== exp_ce_n) begin
                errors = errors + 1;
                $display("mismatch ram_ce_n: got %h expected %h at a=%h", ram_ce_n, exp_ce_n, a);
            end
            if (ram_we_n !== exp_we_n) begin
                errors = errors + 1;
                $display("mismatch ram_we_n: got %h expected %h at a=%h", ram_we_n, exp_we_n, a);
            end
            if (d_oe !== exp_oe) begin
                errors = errors + 1;
                $display("mismatch d_oe: got %h expected %h at a=%h", d_oe, exp_oe, a);
            end
            if (data_check) begin
                checks = checks + 1;
                if (d_out !== exp_d) begin
                    errors = errors + 1;
                    $display("mismatch d_out: got %h expected %h at a=%h", d_out, exp_d, a);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Bus cycle tasks
    ////////////////////////////////////////

    task automatic update_model(input logic io, input logic write, input logic [15:0] addr,
                                input logic [7:0] wdata);
        if (write && io && {addr[7], addr[6], addr[0]} == 3'b001)
            region = {wdata[7], wdata[5]};
        if (write && !io && addr[15:14] == 2'b11) begin
            ram_model[addr[12:0]] = wdata;
            case (addr)
                16'hFFFC: startup = 1'b0;
                16'hFFFD: bank0 = wdata[4:0];
                16'hFFFE: bank1 = wdata[4:0];
                16'hFFFF: bank2 = wdata[4:0];
                default:  ;
            endcase
        end
    endtask

    // Strobes high, address left as it was
    task automatic release_bus;
        rd_n       = 1'b1;
        wr_n       = 1'b1;
        mreq_n     = 1'b1;
        iorq_n     = 1'b1;
        data_check = 1'b0;
        exp_ba     = model_ba(a, bank0, bank1, bank2);
        exp_ce_n   = 1'b1;
        exp_we_n   = 1'b1;
        exp_oe     = 1'b0;
    endtask

    task automatic bus_cycle(input logic io, input logic write, input logic [15:0] addr,
                             input logic [7:0] wdata, input logic [7:0] rdata);
        @(negedge clk);
        a        = addr;
        d_in     = wdata;
        mreq_n   = io;
        iorq_n   = !io;
        rd_n     = write;
        wr_n     = !write;
        exp_ba   = model_ba(addr, bank0, bank1, bank2);
        exp_ce_n = model_ce_n(addr, !io, write, startup);
        exp_we_n = model_we_n(addr, !io, write, startup);
        exp_oe   = !write && (io || addr[15:14] == 2'b11);
        exp_d    = rdata;
        // Work RAM data lags the address by one clock
        repeat (HOLD_CYCLES - 1) begin
            @(negedge clk);
            data_check = !write;
        end
        @(negedge clk);
        update_model(io, write, addr, wdata);
        release_bus();
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] wdata);
        bus_cycle(1'b0, 1'b1, addr, wdata, 8'hFF);
    endtask

    task automatic mem_read(input logic [15:0] addr);
        bus_cycle(1'b0, 1'b0, addr, 8'h00,
                  (addr[15:14] == 2'b11) ? ram_model[addr[12:0]] : 8'hFF);
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] wdata);
        bus_cycle(1'b1, 1'b1, addr, wdata, 8'hFF);
    endtask

    task automatic io_read(input logic [15:0] addr);
        bus_cycle(1'b1, 1'b0, addr, 8'h00, model_port(addr, hc1, hc2, region));
    endtask

    task automatic probe_ba(input logic [15:0] addr);
        @(negedge clk);
        a = addr;
        release_bus();
    endtask

    // Two clocks through the synchronizer, plus one spare
    task automatic set_pads(input logic [7:0] p1, input logic [7:0] p2);
        @(negedge clk);
        hc1 = p1;
        hc2 = p2;
        repeat (2) @(negedge clk);
    endtask

    task automatic report_and_finish;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    ////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////

    initial begin
        int          i;
        logic [15:0] addr;
        clk        = 1'b0;
        reset      = 1'b1;
        a          = '0;
        d_in       = '0;
        rd_n       = 1'b1;
        wr_n       = 1'b1;
        mreq_n     = 1'b1;
        iorq_n     = 1'b1;
        hc1        = 8'hFF;
        hc2        = 8'hFF;
        bank0      = 5'd0;
        bank1      = 5'd1;
        bank2      = 5'd2;
        startup    = 1'b1;
        region     = 2'b11;
        rng        = 32'd82;
        checking   = 1'b0;
        data_check = 1'b0;
        errors     = 0;
        checks     = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        release_bus();
        checking = 1'b1;

        // Mapper defaults, both sides of 0400 in every 4 KB page
        for (i = 0; i < 16; i++) begin
            probe_ba({i[3:0], 12'h000});
            probe_ba({i[3:0], 12'h3FF});
            probe_ba({i[3:0], 12'h400});
        end

        // Bank writes, read back through the work RAM mirror
        for (i = 0; i < 12; i++) begin
            rng  = xorshift32(rng);
            addr = 16'hFFFD + 16'(rng[15:8] % 8'd3);
            mem_write(addr, rng[7:0]);
            mem_read(addr & 16'hDFFF);
            probe_ba({2'b00, rng[29:16]});
            probe_ba({2'b01, rng[29:16]});
            probe_ba({2'b10, rng[29:16]});
        end

        // Nonzero bank 0 so the fixed first 1 KB stands apart
        mem_write(16'hFFFD, 8'h1F);
        probe_ba(16'h03FF);
        probe_ba(16'h0400);

        // External RAM writable only until FFFC
        mem_write(16'h4123, 8'h5A);
        mem_write(16'h0010, 8'hA5);
        mem_write(16'hFFFC, 8'h00);
        mem_write(16'h4123, 8'h5A);
        mem_write(16'h8000, 8'h3C);
        mem_read(16'h4123);
        mem_read(16'h0010);

        // Work RAM, then reads from a random mirror half
        for (i = 0; i < 20; i++) begin
            rng  = xorshift32(rng);
            addr = {2'b11, rng[13:0]};
            if (addr >= 16'hFFFC)
                addr = addr & 16'hDFFF;
            mem_write(addr, rng[23:16]);
            written.push_back(addr);
        end
        foreach (written[k]) begin
            rng = xorshift32(rng);
            mem_read({2'b11, rng[0], written[k][12:0]});
        end
        io_read(16'h0000);
        io_read(16'h0040);
        io_read(16'h007F);

        // Joypad ports, region still at its reset value first
        io_read(16'h00DD);
        for (i = 0; i < 24; i++) begin
            rng = xorshift32(rng);
            set_pads(rng[7:0], rng[15:8]);
            if (rng[16])
                io_write({rng[23:16], 2'b00, rng[21:17], 1'b1}, rng[31:24]);
            io_read({rng[23:16], 2'b11, rng[21:17], 1'b0});
            io_read({rng[23:16], 2'b11, rng[21:17], 1'b1});
        end

        report_and_finish();
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        errors = errors + 1;
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verification
verilog/sms_bus_pkg.sv
verilog/sms_pad_pkg.sv
verilog/bus_strobe_sync.sv
verilog/memory_map.sv
verilog/pad_ports.sv
verilog/bus_readback.sv
verilog/sms_bus_top.sv
verification/tb_sms_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sms_bus
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat list.f)) verification/tb_sms_model.svh

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f list.f

# Fails unless the run reports success
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
